/* test_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared JTAG widths, instruction and TAP state encodings,
// and the bus structs of the test-control block
// Imported by the RTL modules and by the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package test_ctrl_pkg;

	localparam int JTAG_IR_WIDTH = 4;
	localparam int JTAG_DR_WIDTH = 32;

	// Bit 0 must stay one for a valid IDCODE
	localparam logic [JTAG_DR_WIDTH-1:0] JTAG_ID = 32'h2B47_10C3;

	// Default OTP program pulse width
	localparam logic [7:0] OTP_PW_RESET = 8'd10;

	typedef enum logic [JTAG_IR_WIDTH-1:0] {
		IR_IDCODE     = 4'd1,
		IR_SCAN_CFG   = 4'd2,
		IR_OTP_CMD    = 4'd3,
		IR_OTP_STATUS = 4'd4,
		IR_OTP_CFG    = 4'd5,
		IR_BYPASS     = 4'd15
	} jtag_instr_e;

	// Usual 1149.1 state codes
	typedef enum logic [3:0] {
		TAP_EXIT2_DR  = 4'h0,
		TAP_EXIT1_DR  = 4'h1,
		TAP_SHIFT_DR  = 4'h2,
		TAP_PAUSE_DR  = 4'h3,
		TAP_SEL_IR    = 4'h4,
		TAP_UPDATE_DR = 4'h5,
		TAP_CAPTURE_DR = 4'h6,
		TAP_SEL_DR    = 4'h7,
		TAP_EXIT2_IR  = 4'h8,
		TAP_EXIT1_IR  = 4'h9,
		TAP_SHIFT_IR  = 4'hA,
		TAP_PAUSE_IR  = 4'hB,
		TAP_RUN_IDLE  = 4'hC,
		TAP_UPDATE_IR = 4'hD,
		TAP_CAPTURE_IR = 4'hE,
		TAP_TLR       = 4'hF
	} tap_state_e;

	typedef struct packed {
		logic tck;
		logic tms;
		logic tdi;
	} jtag_pad_t;

	typedef struct packed {
		jtag_instr_e              ir;
		logic [JTAG_DR_WIDTH-1:0] dsr;
		logic                     capture_dr;
		logic                     update_dr;
		logic                     test_logic_reset;
		logic                     shift_dr;
	} tap_status_t;

	typedef struct packed {
		logic scan;
		logic compression;
		logic vdd_iload_dis;
		logic vdd_rdiv_dis;
		logic vdd_dis;
		logic disable_osc;
	} scan_cfg_t;

	typedef struct packed {
		logic        valid;
		logic        we;
		logic [7:0]  addr;
		logic [15:0] wdata;
	} otp_cmd_t;

	typedef struct packed {
		logic        valid;
		logic        we;
		logic [7:0]  addr;
		logic [15:0] wdata;
		logic [7:0]  pulse_width;
	} otp_req_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] rdata;
	} otp_rsp_t;

	typedef struct packed {
		logic [15:0] last_rdata;
		logic        read_pending;
		logic        overflow;
		logic        no_credit;
	} otp_status_t;

endpackage

/* jtag_tap.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// JTAG TAP controller sampled on the system clock
// Pads are synchronized, TCK edges are detected on i_clk
// Feeds IR, DSR and the update pulses to the register bank
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jtag_tap (
	input  logic                                   i_clk,
	input  logic                                   i_rst,
	input  test_ctrl_pkg::jtag_pad_t               i_jtag,
	input  logic [test_ctrl_pkg::JTAG_DR_WIDTH-1:0] i_capture_val,
	input  logic                                   i_dr_len_one,
	output test_ctrl_pkg::tap_status_t             o_status,
	output logic                                   o_tdo
);
	import test_ctrl_pkg::*;

	jtag_pad_t                pad_meta;
	jtag_pad_t                pad_sync;
	logic                     tck_last;
	logic                     tck_rise;
	logic                     tck_fall;
	logic                     tck_fall_q;
	tap_state_e               state;
	tap_state_e               state_next;
	logic                     update_ir;
	logic [JTAG_IR_WIDTH-1:0] ir_shift;
	jtag_instr_e              ir;
	logic [JTAG_DR_WIDTH-1:0] dsr;
	logic                     capture_dr_pulse;
	logic                     update_dr_pulse;
	logic                     tlr_pulse;

	// Two flop synchronizer, then edge detect on TCK
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pad_meta <= '0;
			pad_sync <= '0;
			tck_last <= 1'b0;
		end else begin
			pad_meta <= i_jtag;
			pad_sync <= pad_meta;
			tck_last <= pad_sync.tck;
		end
	end

	assign tck_rise = pad_sync.tck & ~tck_last;
	assign tck_fall = ~pad_sync.tck & tck_last;

	always_comb begin
		case (state)
			TAP_TLR:        state_next = pad_sync.tms ? TAP_TLR      : TAP_RUN_IDLE;
			TAP_RUN_IDLE:   state_next = pad_sync.tms ? TAP_SEL_DR   : TAP_RUN_IDLE;
			TAP_SEL_DR:     state_next = pad_sync.tms ? TAP_SEL_IR   : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR: state_next = pad_sync.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:   state_next = pad_sync.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:   state_next = pad_sync.tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:   state_next = pad_sync.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR:   state_next = pad_sync.tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:  state_next = pad_sync.tms ? TAP_SEL_DR   : TAP_RUN_IDLE;
			TAP_SEL_IR:     state_next = pad_sync.tms ? TAP_TLR      : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR: state_next = pad_sync.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:   state_next = pad_sync.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:   state_next = pad_sync.tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:   state_next = pad_sync.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:   state_next = pad_sync.tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			default:        state_next = pad_sync.tms ? TAP_SEL_DR   : TAP_RUN_IDLE;
		endcase
	end

	assign update_ir = tck_rise && (state_next == TAP_UPDATE_IR);

	// State and the one cycle pulses seen by the register bank
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state            <= TAP_TLR;
			capture_dr_pulse <= 1'b0;
			update_dr_pulse  <= 1'b0;
			tlr_pulse        <= 1'b0;
		end else begin
			if (tck_rise)
				state <= state_next;
			capture_dr_pulse <= tck_rise && (state == TAP_CAPTURE_DR);
			update_dr_pulse  <= tck_rise && (state_next == TAP_UPDATE_DR);
			tlr_pulse        <= tck_rise && (state_next == TAP_TLR) && (state != TAP_TLR);
		end
	end

	// Instruction register, back to IDCODE while in Test-Logic-Reset
	always_ff @(posedge i_clk) begin
		if (i_rst)
			ir <= IR_IDCODE;
		else if (update_ir)
			ir <= jtag_instr_e'(ir_shift);
		else if (state == TAP_TLR)
			ir <= IR_IDCODE;
	end

	// Shift paths, LSB first
	always_ff @(posedge i_clk) begin
		if (tck_rise) begin
			case (state)
				TAP_CAPTURE_DR: dsr <= i_capture_val;
				TAP_SHIFT_DR: begin
					if (i_dr_len_one)
						dsr[0] <= pad_sync.tdi;
					else
						dsr <= {pad_sync.tdi, dsr[JTAG_DR_WIDTH-1:1]};
				end
				TAP_CAPTURE_IR: ir_shift <= {{(JTAG_IR_WIDTH-2){1'b0}}, 2'b01};
				TAP_SHIFT_IR:   ir_shift <= {pad_sync.tdi, ir_shift[JTAG_IR_WIDTH-1:1]};
				default: ;
			endcase
		end
	end

	// TDO follows one cycle after the recognized falling edge
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			tck_fall_q <= 1'b0;
			o_tdo      <= 1'b0;
		end else begin
			tck_fall_q <= tck_fall;
			if (tck_fall_q) begin
				if (state == TAP_SHIFT_DR)
					o_tdo <= dsr[0];
				else if (state == TAP_SHIFT_IR)
					o_tdo <= ir_shift[0];
				else
					o_tdo <= 1'b0;
			end
		end
	end

	assign o_status.ir               = ir;
	assign o_status.dsr              = dsr;
	assign o_status.capture_dr       = capture_dr_pulse;
	assign o_status.update_dr        = update_dr_pulse;
	assign o_status.test_logic_reset = tlr_pulse;
	assign o_status.shift_dr         = (state == TAP_SHIFT_DR);

endmodule

/* test_reg_bank.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Test register bank behind the JTAG instruction register
// Supplies the Capture-DR value, takes writes on Update-DR
// and launches OTP commands
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module test_reg_bank (
	input  logic                                    i_clk,
	input  logic                                    i_rst,
	input  test_ctrl_pkg::tap_status_t              i_status,
	input  test_ctrl_pkg::otp_status_t              i_otp_status,
	output logic [test_ctrl_pkg::JTAG_DR_WIDTH-1:0] o_capture_val,
	output logic                                    o_dr_len_one,
	output test_ctrl_pkg::scan_cfg_t                o_scan_cfg,
	output test_ctrl_pkg::otp_cmd_t                 o_otp_cmd,
	output logic [7:0]                              o_pulse_width
);
	import test_ctrl_pkg::*;

	scan_cfg_t   scan_cfg;
	logic [7:0]  pulse_width;
	logic        cmd_write;
	logic        cmd_valid;
	logic        cmd_we;
	logic [7:0]  cmd_addr;
	logic [15:0] cmd_wdata;

	// Capture value and DR length per instruction
	always_comb begin
		o_capture_val = '0;
		o_dr_len_one  = 1'b0;
		case (i_status.ir)
			IR_IDCODE:     o_capture_val = JTAG_ID;
			IR_SCAN_CFG:   o_capture_val = {26'b0, scan_cfg};
			IR_OTP_CMD:    o_capture_val = {cmd_we, 7'b0, cmd_addr, cmd_wdata};
			IR_OTP_STATUS: begin
				o_capture_val = {i_otp_status.no_credit, i_otp_status.overflow,
					i_otp_status.read_pending, 13'b0, i_otp_status.last_rdata};
			end
			IR_OTP_CFG:    o_capture_val = {24'b0, pulse_width};
			IR_BYPASS:     o_dr_len_one = 1'b1;
			// Unknown codes act as BYPASS
			default:       o_dr_len_one = 1'b1;
		endcase
	end

	assign cmd_write = i_status.update_dr && (i_status.ir == IR_OTP_CMD);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			scan_cfg    <= '0;
			pulse_width <= OTP_PW_RESET;
			cmd_valid   <= 1'b0;
		end else begin
			cmd_valid <= cmd_write;
			if (i_status.update_dr) begin
				case (i_status.ir)
					IR_SCAN_CFG: scan_cfg <= scan_cfg_t'(i_status.dsr[5:0]);
					IR_OTP_CFG:  pulse_width <= i_status.dsr[7:0];
					default: ;
				endcase
			end
		end
	end

	// Command fields, bit 31 is write enable
	always_ff @(posedge i_clk) begin
		if (cmd_write) begin
			cmd_we    <= i_status.dsr[31];
			cmd_addr  <= i_status.dsr[23:16];
			cmd_wdata <= i_status.dsr[15:0];
		end
	end

	assign o_otp_cmd.valid = cmd_valid;
	assign o_otp_cmd.we    = cmd_we;
	assign o_otp_cmd.addr  = cmd_addr;
	assign o_otp_cmd.wdata = cmd_wdata;

	assign o_scan_cfg    = scan_cfg;
	assign o_pulse_width = pulse_width;

endmodule

/* otp_access.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OTP access engine with credit based flow control
// One pending slot absorbs a command while no credit is left
// Tracks overflow and the data of the last read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module otp_access #(
	parameter int OTP_CREDITS = 2
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  test_ctrl_pkg::otp_cmd_t     i_cmd,
	input  logic [7:0]                  i_pulse_width,
	input  logic                        i_credit,
	input  test_ctrl_pkg::otp_rsp_t     i_rsp,
	output test_ctrl_pkg::otp_req_t     o_req,
	output test_ctrl_pkg::otp_status_t  o_status
);
	import test_ctrl_pkg::*;

	localparam int CREDIT_W = $clog2(OTP_CREDITS + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(OTP_CREDITS);

	logic [CREDIT_W-1:0] credits;
	logic                pend_valid;
	otp_cmd_t            pend_cmd;
	logic                send_new;
	logic                send_pend;
	logic                overflow;
	logic                read_pending;
	logic [15:0]         last_rdata;

	// Slot first, a new command only when the slot is empty
	assign send_pend = pend_valid && (credits != '0);
	assign send_new  = i_cmd.valid && !pend_valid && (credits != '0);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			credits      <= CREDIT_MAX;
			pend_valid   <= 1'b0;
			overflow     <= 1'b0;
			read_pending <= 1'b0;
			o_req.valid  <= 1'b0;
		end else begin
			o_req.valid <= send_new || send_pend;
			if ((send_new || send_pend) && !i_credit)
				credits <= credits - 1'b1;
			else if (!(send_new || send_pend) && i_credit && (credits != CREDIT_MAX))
				credits <= credits + 1'b1;
			// Slot refills in the same cycle it drains
			if (i_cmd.valid && !send_new && (!pend_valid || send_pend))
				pend_valid <= 1'b1;
			else if (send_pend)
				pend_valid <= 1'b0;
			if (i_cmd.valid && pend_valid && !send_pend)
				overflow <= 1'b1;
			if (o_req.valid && !o_req.we)
				read_pending <= 1'b1;
			else if (i_rsp.valid)
				read_pending <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		// A dropped command leaves the slot untouched
		if (i_cmd.valid && !send_new && (!pend_valid || send_pend))
			pend_cmd <= i_cmd;
		if (send_pend) begin
			o_req.we    <= pend_cmd.we;
			o_req.addr  <= pend_cmd.addr;
			o_req.wdata <= pend_cmd.wdata;
		end else if (send_new) begin
			o_req.we    <= i_cmd.we;
			o_req.addr  <= i_cmd.addr;
			o_req.wdata <= i_cmd.wdata;
		end
		if (send_pend || send_new)
			o_req.pulse_width <= i_pulse_width;
		if (i_rsp.valid)
			last_rdata <= i_rsp.rdata;
	end

	assign o_status.last_rdata   = last_rdata;
	assign o_status.read_pending = read_pending;
	assign o_status.overflow     = overflow;
	assign o_status.no_credit    = (credits == '0);

endmodule

/* resb_reset_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System reset generator
// Synchronizes RESB and PORB, debounces RESB
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module resb_reset_gen #(
	parameter int DEB_CYCLES = 16
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_resb,
	input  logic i_porb,
	output logic o_sys_rst
);
	localparam int CNT_W = $clog2(DEB_CYCLES + 1);

	logic [1:0]       resb_sync;
	logic [1:0]       porb_sync;
	logic             resb_deb;
	logic [CNT_W-1:0] deb_cnt;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			resb_sync <= 2'b00;
			porb_sync <= 2'b00;
			resb_deb  <= 1'b0;
			deb_cnt   <= '0;
		end else begin
			resb_sync <= {resb_sync[0], i_resb};
			porb_sync <= {porb_sync[0], i_porb};
			// Count only while the synchronized level differs
			if (resb_sync[1] == resb_deb) begin
				deb_cnt <= '0;
			end else if (deb_cnt == CNT_W'(DEB_CYCLES - 1)) begin
				deb_cnt  <= '0;
				resb_deb <= resb_sync[1];
			end else begin
				deb_cnt <= deb_cnt + 1'b1;
			end
		end
	end

	assign o_sys_rst = i_rst | ~porb_sync[1] | ~resb_deb;

endmodule

/* test_control.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Test-control top level
// TAP, test registers, OTP access engine and reset generator
// Parameters set here are passed to the submodules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module test_control #(
	parameter int DEB_CYCLES  = 16,
	parameter int OTP_CREDITS = 2
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  test_ctrl_pkg::jtag_pad_t    i_jtag,
	output logic                        o_tdo,
	input  logic                        i_resb,
	input  logic                        i_porb,
	output logic                        o_sys_rst,
	output test_ctrl_pkg::scan_cfg_t    o_scan_cfg,
	output test_ctrl_pkg::otp_req_t     o_otp_req,
	input  logic                        i_otp_credit,
	input  test_ctrl_pkg::otp_rsp_t     i_otp_rsp
);
	import test_ctrl_pkg::*;

	tap_status_t              tap_status;
	logic [JTAG_DR_WIDTH-1:0] capture_val;
	logic                     dr_len_one;
	otp_cmd_t                 otp_cmd;
	otp_status_t              otp_status;
	logic [7:0]               pulse_width;

	jtag_tap jtag_tap_inst (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_jtag        (i_jtag),
		.i_capture_val (capture_val),
		.i_dr_len_one  (dr_len_one),
		.o_status      (tap_status),
		.o_tdo         (o_tdo)
	);

	test_reg_bank test_reg_bank_inst (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_status      (tap_status),
		.i_otp_status  (otp_status),
		.o_capture_val (capture_val),
		.o_dr_len_one  (dr_len_one),
		.o_scan_cfg    (o_scan_cfg),
		.o_otp_cmd     (otp_cmd),
		.o_pulse_width (pulse_width)
	);

	// OTP side runs on the generated system reset
	otp_access #(
		.OTP_CREDITS (OTP_CREDITS)
	) otp_access_inst (
		.i_clk         (i_clk),
		.i_rst         (o_sys_rst),
		.i_cmd         (otp_cmd),
		.i_pulse_width (pulse_width),
		.i_credit      (i_otp_credit),
		.i_rsp         (i_otp_rsp),
		.o_req         (o_otp_req),
		.o_status      (otp_status)
	);

	resb_reset_gen #(
		.DEB_CYCLES (DEB_CYCLES)
	) resb_reset_gen_inst (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_resb    (i_resb),
		.i_porb    (i_porb),
		.o_sys_rst (o_sys_rst)
	);

endmodule

/* test_control_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the reset and OTP credit rules
// Bound into test_control from the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module test_control_checker #(
	parameter int DEB_CYCLES = 16
) (
	input logic i_clk,
	input logic i_rst,
	input logic i_resb,
	input logic i_porb,
	input logic i_sys_rst,
	input logic i_req_valid,
	input logic i_no_credit,
	input logic i_tdo
);

	// Long RESB low passes two synchronizer flops and the debounce
	a_resb_to_sys_rst: assert property (@(posedge i_clk)
		(!i_resb) [*DEB_CYCLES + 3] |-> i_sys_rst)
		else $error("system reset not high after a long RESB low");

	// PORB low is seen after the two synchronizer flops
	a_porb_to_sys_rst: assert property (@(posedge i_clk) (!i_porb) [*3] |-> i_sys_rst)
		else $error("system reset not high after PORB low");

	// No credit left means no request on the next cycle
	a_no_credit_no_req: assert property (@(posedge i_clk) disable iff (i_sys_rst)
		i_no_credit |=> !i_req_valid)
		else $error("OTP request sent without a credit");

	a_req_idle_after_rst: assert property (@(posedge i_clk) $fell(i_sys_rst) |-> !i_req_valid)
		else $error("OTP request valid when system reset ends");

	a_tdo_low_after_rst: assert property (@(posedge i_clk) i_rst |=> !i_tdo)
		else $error("TDO not low after reset");

endmodule

/* tb_test_control.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the test-control block
// Drives JTAG through a bit task, models the OTP macro with
// delayed credits and checks requests against a queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_test_control;
	import test_ctrl_pkg::*;

	localparam int DEB_CYCLES  = 16;
	localparam int OTP_CREDITS = 2;
	localparam int HALF        = 6;
	localparam int MAX_CYCLES  = 60000;

	logic        i_clk;
	logic        i_rst;
	jtag_pad_t   jtag;
	logic        o_tdo;
	logic        resb;
	logic        porb;
	logic        o_sys_rst;
	scan_cfg_t   o_scan_cfg;
	otp_req_t    o_otp_req;
	logic        otp_credit;
	otp_rsp_t    otp_rsp;

	int          cycle;
	int          errors;
	int          err_mark;
	int          tests_run;
	int          tests_failed;
	int          avail;
	bit          hold_credits;
	logic [15:0] otp_mem [256];
	int          credit_due [$];
	int          rsp_due [$];
	logic [15:0] rsp_data [$];
	logic [15:0] last_read_data;
	otp_req_t    exp_q [$];
	logic [7:0]  pw_reg;

	test_control #(
		.DEB_CYCLES  (DEB_CYCLES),
		.OTP_CREDITS (OTP_CREDITS)
	) test_control_inst (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_jtag       (jtag),
		.o_tdo        (o_tdo),
		.i_resb       (resb),
		.i_porb       (porb),
		.o_sys_rst    (o_sys_rst),
		.o_scan_cfg   (o_scan_cfg),
		.o_otp_req    (o_otp_req),
		.i_otp_credit (otp_credit),
		.i_otp_rsp    (otp_rsp)
	);

	bind test_control test_control_checker #(
		.DEB_CYCLES (DEB_CYCLES)
	) checker_inst (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_resb      (i_resb),
		.i_porb      (i_porb),
		.i_sys_rst   (o_sys_rst),
		.i_req_valid (o_otp_req.valid),
		.i_no_credit (otp_status.no_credit),
		.i_tdo       (o_tdo)
	);

	always #10 i_clk = ~i_clk;

	// Expected DR words
	function automatic logic [31:0] status_word(input logic no_credit, input logic overflow,
		input logic rd_pend, input logic [15:0] rdata);
		return {no_credit, overflow, rd_pend, 13'b0, rdata};
	endfunction

	function automatic logic [31:0] cmd_word(input logic we, input logic [7:0] addr,
		input logic [15:0] wdata);
		return {we, 7'b0, addr, wdata};
	endfunction

	function automatic logic [31:0] scan_cfg_word(input logic [5:0] cfg);
		return {26'b0, cfg};
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: failed", num, name);
			tests_failed++;
		end
		err_mark = errors;
	endtask

	// One TCK period, TDO is sampled late in the low phase
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		@(posedge i_clk);
		jtag.tck <= 1'b0;
		jtag.tms <= tms;
		jtag.tdi <= tdi;
		repeat (HALF) @(posedge i_clk);
		tdo = o_tdo;
		jtag.tck <= 1'b1;
		repeat (HALF - 1) @(posedge i_clk);
	endtask

	// From Run-Test/Idle back to Run-Test/Idle
	task automatic shift_ir(input logic [3:0] code);
		logic t;
		tck_cycle(1'b1, 1'b0, t);
		tck_cycle(1'b1, 1'b0, t);
		tck_cycle(1'b0, 1'b0, t);
		tck_cycle(1'b0, 1'b0, t);
		for (int i = 0; i < 4; i++)
			tck_cycle(i == 3, code[i], t);
		tck_cycle(1'b1, 1'b0, t);
		tck_cycle(1'b0, 1'b0, t);
	endtask

	task automatic shift_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
		logic t;
		dout = '0;
		tck_cycle(1'b1, 1'b0, t);
		tck_cycle(1'b0, 1'b0, t);
		tck_cycle(1'b0, 1'b0, t);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], t);
			dout[i] = t;
		end
		tck_cycle(1'b1, 1'b0, t);
		tck_cycle(1'b0, 1'b0, t);
	endtask

	task automatic send_command(input logic we, input logic [7:0] addr, input logic [15:0] wdata,
		input bit kept);
		logic [31:0] d;
		if (kept)
			exp_q.push_back('{valid: 1'b1, we: we, addr: addr, wdata: wdata, pulse_width: pw_reg});
		shift_dr(cmd_word(we, addr, wdata), 32, d);
	endtask

	task automatic read_status(output logic [31:0] word);
		shift_ir(IR_OTP_STATUS);
		shift_dr(32'h0, 32, word);
	endtask

	task automatic wait_sys_rst(input logic level, input int limit);
		int n;
		n = 0;
		while (o_sys_rst !== level && n < limit) begin
			@(posedge i_clk);
			n++;
		end
		if (o_sys_rst !== level) begin
			$display("o_sys_rst did not reach %0b within %0d cycles", level, limit);
			errors++;
		end
	endtask

	task automatic wait_otp_idle(input int limit);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || credit_due.size() != 0 || rsp_due.size() != 0
			|| avail != OTP_CREDITS) && n < limit) begin
			@(posedge i_clk);
			n++;
		end
		if (n >= limit) begin
			$display("OTP traffic did not drain within %0d cycles", limit);
			errors++;
		end
		repeat (4) @(posedge i_clk);
	endtask

	// OTP macro model: in order read data, credits 3 to 10 cycles late
	always @(posedge i_clk) begin : otp_model
		int  due;
		bit  found;
		otp_credit <= 1'b0;
		otp_rsp    <= '0;
		if (o_sys_rst) begin
			credit_due.delete();
			rsp_due.delete();
			rsp_data.delete();
		end else begin
			if (o_otp_req.valid) begin
				credit_due.push_back(cycle + 3 + int'($urandom_range(7)));
				if (o_otp_req.we) begin
					otp_mem[o_otp_req.addr] = o_otp_req.wdata;
				end else begin
					due = cycle + 1 + int'($urandom_range(7));
					if (rsp_due.size() > 0 && due <= rsp_due[$])
						due = rsp_due[$] + 1;
					rsp_due.push_back(due);
					rsp_data.push_back(otp_mem[o_otp_req.addr]);
					last_read_data = otp_mem[o_otp_req.addr];
				end
			end
			found = 0;
			if (!hold_credits) begin
				foreach (credit_due[k]) begin
					if (!found && credit_due[k] <= cycle) begin
						found = 1;
						credit_due.delete(k);
					end
				end
			end
			if (found)
				otp_credit <= 1'b1;
			if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
				void'(rsp_due.pop_front());
				otp_rsp <= '{valid: 1'b1, rdata: rsp_data.pop_front()};
			end
		end
	end

	// Request compare and credit count
	always @(posedge i_clk) begin : req_compare
		otp_req_t e;
		if (o_sys_rst) begin
			avail = OTP_CREDITS;
		end else begin
			if (o_otp_req.valid) begin
				if (avail == 0) begin
					$display("%0t request sent while no credit was outstanding", $time);
					errors++;
				end else begin
					avail--;
				end
				if (exp_q.size() == 0) begin
					$display("%0t unexpected OTP request", $time);
					errors++;
				end else begin
					e = exp_q.pop_front();
					if ({e.we, e.addr, e.wdata, e.pulse_width} !== {o_otp_req.we,
						o_otp_req.addr, o_otp_req.wdata, o_otp_req.pulse_width}) begin
						$display("[FAIL] %0t o_otp_req expected %h got %h", $time, e, o_otp_req);
						errors++;
					end
				end
			end
			if (otp_credit)
				avail++;
			if (avail > OTP_CREDITS) begin
				$display("%0t more credits returned than requests sent", $time);
				errors++;
			end
		end
	end

	always @(posedge i_clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout after %0d cycles", cycle);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin : stimulus
		logic [31:0] d;
		logic [31:0] din;
		logic [5:0]  cfg;
		logic [7:0]  addr [4];
		logic [15:0] data [4];
		logic        t;
		void'($urandom(32'h759c_e885));
		i_clk = 1'b0;
		i_rst = 1'b1;
		jtag  = '{tck: 1'b0, tms: 1'b1, tdi: 1'b0};
		resb  = 1'b1;
		porb  = 1'b1;
		otp_credit = 1'b0;
		otp_rsp    = '0;
		hold_credits = 0;
		pw_reg = OTP_PW_RESET;
		avail  = OTP_CREDITS;
		for (int a = 0; a < 256; a++)
			otp_mem[a] = {a[7:0], ~a[7:0]};
		repeat (3) @(posedge i_clk);
		i_rst <= 1'b0;
		wait_sys_rst(1'b0, 200);

		// 1: IDCODE after Test-Logic-Reset
		repeat (5) tck_cycle(1'b1, 1'b0, t);
		tck_cycle(1'b0, 1'b0, t);
		shift_dr(32'h0, 32, d);
		check_word("idcode", JTAG_ID, d);
		check_word("o_scan_cfg", 32'h0, scan_cfg_word(o_scan_cfg));
		report_test(1, "idcode");

		// 2: BYPASS and an unknown code give a one bit delay
		for (int c = 0; c < 2; c++) begin
			shift_ir(c == 0 ? 4'(IR_BYPASS) : 4'd7);
			din = $urandom;
			shift_dr(din, 8, d);
			check_word("o_tdo bypass", {24'b0, din[6:0], 1'b0}, d);
		end
		report_test(2, "bypass");

		// 3: Configuration registers
		for (int r = 0; r < 3; r++) begin
			cfg = 6'($urandom);
			shift_ir(IR_SCAN_CFG);
			shift_dr(scan_cfg_word(cfg), 32, d);
			check_word("o_scan_cfg", scan_cfg_word(cfg), scan_cfg_word(o_scan_cfg));
			shift_dr(scan_cfg_word(cfg), 32, d);
			check_word("scan_cfg readback", scan_cfg_word(cfg), d);
			pw_reg = 8'($urandom);
			shift_ir(IR_OTP_CFG);
			shift_dr({24'b0, pw_reg}, 32, d);
			shift_dr({24'b0, pw_reg}, 32, d);
			check_word("otp_cfg readback", {24'b0, pw_reg}, d);
		end
		report_test(3, "config registers");

		// 4: Writes then reads of the same addresses
		shift_ir(IR_OTP_CMD);
		for (int i = 0; i < 4; i++) begin
			addr[i] = 8'($urandom);
			data[i] = 16'($urandom);
			send_command(1'b1, addr[i], data[i], 1);
		end
		for (int i = 0; i < 4; i++)
			send_command(1'b0, addr[i], 16'h0, 1);
		wait_otp_idle(2000);
		read_status(d);
		check_word("otp_status", status_word(1'b0, 1'b0, 1'b0, last_read_data), d);
		report_test(4, "otp write read");

		// 5: Withheld credits, overflow of the pending slot
		hold_credits = 1;
		shift_ir(IR_OTP_CMD);
		for (int i = 0; i < OTP_CREDITS + 3; i++)
			send_command(1'b1, 8'($urandom), 16'($urandom), i < OTP_CREDITS + 1);
		read_status(d);
		check_word("otp_status", status_word(1'b1, 1'b1, 1'b0, last_read_data), d);
		hold_credits = 0;
		wait_otp_idle(2000);
		report_test(5, "credit overflow");

		// 6: RESB debounce and PORB
		@(posedge i_clk);
		resb <= 1'b0;
		repeat (DEB_CYCLES / 2) @(posedge i_clk);
		resb <= 1'b1;
		for (int i = 0; i < 3 * DEB_CYCLES; i++) begin
			@(posedge i_clk);
			if (o_sys_rst !== 1'b0) begin
				$display("[FAIL] %0t o_sys_rst expected 0 got %b", $time, o_sys_rst);
				errors++;
			end
		end
		resb <= 1'b0;
		wait_sys_rst(1'b1, DEB_CYCLES + 10);
		repeat (DEB_CYCLES) @(posedge i_clk);
		resb <= 1'b1;
		wait_sys_rst(1'b0, DEB_CYCLES + 10);
		read_status(d);
		check_word("otp_status flags", 32'h0, {29'b0, d[31:29]});
		@(posedge i_clk);
		porb <= 1'b0;
		wait_sys_rst(1'b1, 10);
		porb <= 1'b1;
		wait_sys_rst(1'b0, 10);
		report_test(6, "reset generator");

		$display("tests %0d, failed tests %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* sim.f */
test_ctrl_pkg.sv
jtag_tap.sv
test_reg_bank.sv
otp_access.sv
resb_reset_gen.sv
test_control.sv
test_control_checker.sv
tb_test_control.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the test-control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_test_control

out=$(./obj_dir/Vtb_test_control)
echo "$out"

if echo "$out" | grep -q '\*\*\* PASSED \*\*\*'; then
	exit 0
fi
exit 1
